// File: hdl/opval_settings.svh
/*
  Size settings for the operand-capture stage
  OPV_NPREG must be a power of two because tags are log2 of it wide
  OPV_NENTRY must be at least two
*/
`ifndef OPVAL_SETTINGS_SVH
`define OPVAL_SETTINGS_SVH

// Number of physical registers in the register file
`define OPV_NPREG 32

// Width of one operand value in bits
`define OPV_DWIDTH 32

// Number of entries in the operand station
`define OPV_NENTRY 4

// Width of the instruction id carried through the stage
`define OPV_IDW 8

`endif

// File: hdl/cpu_types_pkg.sv
/*
  Register and operand types shared by the register file,
  the validator and the operand station
  The tag width follows OPV_NPREG from the settings header
*/
`include "opval_settings.svh"

package cpu_types_pkg;

	// ==================================================
	// Register tags and values
	// ==================================================

	// A physical register tag addresses one of OPV_NPREG registers
	typedef logic [$clog2(`OPV_NPREG)-1:0] preg_t;

	// One operand value as held in the register file
	typedef logic [`OPV_DWIDTH-1:0] value_t;

	// All-zero value used for reset and for fresh operand records
	localparam value_t value_zero = '0;

	// ==================================================
	// Operand record
	// ==================================================

	// The record a waiting instruction keeps for one source
	// pRn names the physical register the value comes from
	// When v is set, val holds the captured value
	typedef struct packed {
		preg_t pRn;
		logic v;
		value_t val;
	} operand_t;

endpackage

// File: hdl/sched_pkg.sv
/*
  Packet types for the issue, dispatch and writeback links and the
  layout of one operand station entry
  Field order is fixed since the packets cross module ports as vectors
*/
`include "opval_settings.svh"

package sched_pkg;

	// Instruction id as given by the issue stage
	typedef logic [`OPV_IDW-1:0] id_t;

	// Issue packet with the destination and both source tags
	typedef struct packed {
		id_t id;
		cpu_types_pkg::preg_t dst;
		cpu_types_pkg::preg_t src_a;
		cpu_types_pkg::preg_t src_b;
	} issue_t;

	// Dispatch packet sent to the functional unit with values attached
	typedef struct packed {
		id_t id;
		cpu_types_pkg::preg_t dst;
		cpu_types_pkg::value_t val_a;
		cpu_types_pkg::value_t val_b;
	} dispatch_t;

	// Writeback packet returned by the functional unit
	typedef struct packed {
		cpu_types_pkg::preg_t tag;
		cpu_types_pkg::value_t val;
	} wb_t;

	// One waiting instruction in the station
	typedef struct packed {
		logic busy;
		id_t id;
		cpu_types_pkg::preg_t dst;
		cpu_types_pkg::operand_t src_a;
		cpu_types_pkg::operand_t src_b;
	} rs_entry_t;

endpackage

// File: hdl/req_ack_rx.sv
/*
  Receiving side of a four-phase req/ack link
  The sender must hold data_i stable while req_i is high
  A new payload is taken only after req_i has dropped and ack_o
  has been released, and only while ready_i is high
*/
`timescale 1ns/1ps

module req_ack_rx #(
	parameter type PAYLOAD_T = logic
) (
	input  logic     clk_i,
	input  logic     rst_i,
	input  logic     req_i,
	input  PAYLOAD_T data_i,
	input  logic     ready_i,
	output logic     ack_o,
	output logic     valid_o,
	output PAYLOAD_T data_o
);

	// A low ack_o means req_i has been seen low since the last handshake
	// so a high req_i here is a fresh request
	logic take;

	assign take = req_i && ready_i && !ack_o;

	// Handshake state and the one-cycle capture strobe
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ack_o <= 1'b0;
			valid_o <= 1'b0;
		end else begin
			valid_o <= take;
			if (take) begin
				ack_o <= 1'b1;
			end else if (ack_o && !req_i) begin
				// Sender has let go so release the link
				ack_o <= 1'b0;
			end
		end
	end

	// Payload holds until the next handshake
	always_ff @(posedge clk_i) begin
		if (take) begin
			data_o <= data_i;
		end
	end

endmodule

// File: hdl/phys_regfile.sv
/*
  Physical register file with a ready bit per register
  An allocation clears the ready bit of the new destination
  A writeback sets it and stores the value, and wins over an
  allocation of the same tag in the same cycle
  Reads are combinational and see the state before the clock edge
*/
`timescale 1ns/1ps
`include "opval_settings.svh"

module phys_regfile (
	input  logic                                              clk_i,
	input  logic                                              rst_i,
	input  logic                                              alloc_i,
	input  cpu_types_pkg::preg_t                              alloc_tag_i,
	input  logic                                              wr_i,
	input  sched_pkg::wb_t                                    wr_data_i,
	input  cpu_types_pkg::preg_t   [2*`OPV_NENTRY-1:0]        rd_tag_i,
	output cpu_types_pkg::operand_t [2*`OPV_NENTRY-1:0]       rd_oper_o
);

	// Register values and their ready bits
	cpu_types_pkg::value_t regs [`OPV_NPREG];
	logic [`OPV_NPREG-1:0] rdy;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			// Every register comes out of reset as zero and ready
			rdy <= '1;
			for (int rr = 0; rr < `OPV_NPREG; rr++) begin
				regs[rr] <= cpu_types_pkg::value_zero;
			end
		end else begin
			if (alloc_i) begin
				rdy[alloc_tag_i] <= 1'b0;
			end
			// Placed after the allocation so the write wins on a tag clash
			if (wr_i) begin
				rdy[wr_data_i.tag] <= 1'b1;
				regs[wr_data_i.tag] <= wr_data_i.val;
			end
		end
	end

	// One read port per waiting operand
	// The tag is echoed back so the validator can match on it
	always_comb begin
		for (int pp = 0; pp < 2*`OPV_NENTRY; pp++) begin
			rd_oper_o[pp].pRn = rd_tag_i[pp];
			rd_oper_o[pp].v = rdy[rd_tag_i[pp]];
			rd_oper_o[pp].val = regs[rd_tag_i[pp]];
		end
	end

endmodule

// File: hdl/validate_operand.sv
/*
  Operand validation for all station operands at once
  Pure combinational logic with no clock
  A valid operand passes through untouched
  For a missing operand the writeback bypass has priority over a
  ready register file read of the same tag
*/
`timescale 1ns/1ps
`include "opval_settings.svh"

module validate_operand (
	input  cpu_types_pkg::operand_t [2*`OPV_NENTRY-1:0] oper_i,
	input  cpu_types_pkg::operand_t [2*`OPV_NENTRY-1:0] rf_oper_i,
	input  sched_pkg::wb_t                               bypass_i,
	input  logic                                         bypass_v_i,
	output cpu_types_pkg::operand_t [2*`OPV_NENTRY-1:0] oper_o
);

	// ==================================================
	// Register file match
	// ==================================================

	// Read port nn carries the tag of operand nn
	always_comb begin
		for (int nn = 0; nn < 2*`OPV_NENTRY; nn++) begin
			oper_o[nn] = oper_i[nn];
			if (!oper_i[nn].v && rf_oper_i[nn].v &&
				rf_oper_i[nn].pRn == oper_i[nn].pRn) begin
				oper_o[nn].val = rf_oper_i[nn].val;
				oper_o[nn].v = 1'b1;
			end

			// ==================================================
			// Writeback bypass
			// ==================================================

			// The bypass value is the one being written this cycle
			// It is newer than what the register file read shows
			if (!oper_i[nn].v && bypass_v_i && bypass_i.tag == oper_i[nn].pRn) begin
				oper_o[nn].val = bypass_i.val;
				oper_o[nn].v = 1'b1;
			end
		end
	end

endmodule

// File: hdl/operand_station.sv
/*
  Operand station holding instructions until both sources are valid
  New instructions go to the lowest free entry with both operands
  marked missing
  Age is tracked with a matrix so the oldest ready entry is offered
  An offered entry is freed in the cycle take_i is high
*/
`timescale 1ns/1ps
`include "opval_settings.svh"

module operand_station (
	input  logic                                         clk_i,
	input  logic                                         rst_i,
	input  logic                                         issue_v_i,
	input  sched_pkg::issue_t                            issue_i,
	output logic                                         free_o,
	output cpu_types_pkg::preg_t   [2*`OPV_NENTRY-1:0]   rd_tag_o,
	output cpu_types_pkg::operand_t [2*`OPV_NENTRY-1:0]  oper_o,
	input  cpu_types_pkg::operand_t [2*`OPV_NENTRY-1:0]  oper_i,
	input  logic                                         take_i,
	output logic                                         offer_v_o,
	output sched_pkg::dispatch_t                         offer_o
);

	localparam int IW = $clog2(`OPV_NENTRY);

	sched_pkg::rs_entry_t ent [`OPV_NENTRY];

	// older[j][i] is set when entry j was issued before entry i
	logic [`OPV_NENTRY-1:0] older [`OPV_NENTRY];
	logic [`OPV_NENTRY-1:0] busy;
	logic [`OPV_NENTRY-1:0] rdy;
	logic [IW-1:0] alloc_idx;
	logic [IW-1:0] sel;

	// ==================================================
	// Allocation and operand exposure
	// ==================================================

	always_comb begin
		alloc_idx = '0;
		for (int i = 0; i < `OPV_NENTRY; i++) begin
			busy[i] = ent[i].busy;
			rdy[i] = ent[i].busy && ent[i].src_a.v && ent[i].src_b.v;
			// Operand a sits at the even slot and operand b at the odd one
			rd_tag_o[2*i] = ent[i].src_a.pRn;
			rd_tag_o[2*i+1] = ent[i].src_b.pRn;
			oper_o[2*i] = ent[i].src_a;
			oper_o[2*i+1] = ent[i].src_b;
		end
		// Scan downward so the lowest free entry is the last one kept
		for (int i = `OPV_NENTRY-1; i >= 0; i--) begin
			if (!busy[i]) begin
				alloc_idx = IW'(i);
			end
		end
	end

	assign free_o = ~&busy;

	// ==================================================
	// Oldest ready selection
	// ==================================================

	always_comb begin
		logic oldest;
		sel = '0;
		offer_v_o = 1'b0;
		for (int i = 0; i < `OPV_NENTRY; i++) begin
			oldest = rdy[i];
			// Any other ready entry that is older rules this one out
			for (int j = 0; j < `OPV_NENTRY; j++) begin
				if (j != i && rdy[j] && older[j][i]) begin
					oldest = 1'b0;
				end
			end
			if (oldest) begin
				sel = IW'(i);
				offer_v_o = 1'b1;
			end
		end
		offer_o.id = ent[sel].id;
		offer_o.dst = ent[sel].dst;
		offer_o.val_a = ent[sel].src_a.val;
		offer_o.val_b = ent[sel].src_b.val;
	end

	// ==================================================
	// Entry update
	// ==================================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int i = 0; i < `OPV_NENTRY; i++) begin
				ent[i].busy <= 1'b0;
				older[i] <= '0;
			end
		end else begin
			for (int i = 0; i < `OPV_NENTRY; i++) begin
				// Capture validated operands only where still missing
				if (ent[i].busy && !ent[i].src_a.v) begin
					ent[i].src_a <= oper_i[2*i];
				end
				if (ent[i].busy && !ent[i].src_b.v) begin
					ent[i].src_b <= oper_i[2*i+1];
				end
				if (take_i && sel == IW'(i)) begin
					ent[i].busy <= 1'b0;
				end
				// Everything busy now is older than the new entry
				if (issue_v_i) begin
					older[i][alloc_idx] <= busy[i];
				end
				if (issue_v_i && alloc_idx == IW'(i)) begin
					ent[i].busy <= 1'b1;
					ent[i].id <= issue_i.id;
					ent[i].dst <= issue_i.dst;
					ent[i].src_a <= '{pRn: issue_i.src_a, v: 1'b0,
						val: cpu_types_pkg::value_zero};
					ent[i].src_b <= '{pRn: issue_i.src_b, v: 1'b0,
						val: cpu_types_pkg::value_zero};
					older[i] <= '0;
				end
			end
		end
	end

endmodule

// File: hdl/dispatch_tx.sv
/*
  Sending side of the four-phase dispatch link
  An offer is taken only while idle, and req_o rises on the next edge
  The packet stays on data_o until the next offer is taken
  No new offer is taken before the receiver drops ack_i
*/
`timescale 1ns/1ps

module dispatch_tx (
	input  logic                 clk_i,
	input  logic                 rst_i,
	input  logic                 offer_v_i,
	input  sched_pkg::dispatch_t offer_i,
	output logic                 take_o,
	output logic                 req_o,
	output sched_pkg::dispatch_t data_o,
	input  logic                 ack_i
);

	typedef enum logic [1:0] {
		st_idle,
		st_req,
		st_release
	} state_t;

	state_t state;

	// The station frees the entry in the same cycle as this strobe
	assign take_o = (state == st_idle) && offer_v_i;
	assign req_o = (state == st_req);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: if (take_o) state <= st_req;
				// Receiver has the packet so req can drop
				st_req: if (ack_i) state <= st_release;
				st_release: if (!ack_i) state <= st_idle;
				default: state <= st_idle;
			endcase
		end
	end

	// Packet register loads with the offer it takes
	always_ff @(posedge clk_i) begin
		if (take_o) begin
			data_o <= offer_i;
		end
	end

endmodule

// File: hdl/opval_top.sv
/*
  Operand-capture stage top level
  Issue and writeback arrive over four-phase links and instructions
  leave over a third one with their operand values attached
  Issue is back-pressured by withholding ack while the station is full
*/
`timescale 1ns/1ps
`include "opval_settings.svh"

module opval_top (
	input  logic                 clk_i,
	input  logic                 rst_i,
	input  logic                 issue_req_i,
	input  sched_pkg::issue_t    issue_data_i,
	output logic                 issue_ack_o,
	input  logic                 wb_req_i,
	input  sched_pkg::wb_t       wb_data_i,
	output logic                 wb_ack_o,
	output logic                 disp_req_o,
	output sched_pkg::dispatch_t disp_data_o,
	input  logic                 disp_ack_i
);

	sched_pkg::issue_t issue_q;
	logic issue_v;
	sched_pkg::wb_t wb_q;
	logic wb_v;
	logic st_free;
	cpu_types_pkg::preg_t [2*`OPV_NENTRY-1:0] rd_tag;
	cpu_types_pkg::operand_t [2*`OPV_NENTRY-1:0] rf_oper;
	cpu_types_pkg::operand_t [2*`OPV_NENTRY-1:0] st_oper;
	cpu_types_pkg::operand_t [2*`OPV_NENTRY-1:0] val_oper;
	logic take;
	logic offer_v;
	sched_pkg::dispatch_t offer;

	// ==================================================
	// Input links
	// ==================================================

	// Issue is only acknowledged while a station entry is free
	req_ack_rx #(.PAYLOAD_T(sched_pkg::issue_t)) issue_rx_inst (
		.clk_i(clk_i), .rst_i(rst_i), .req_i(issue_req_i), .data_i(issue_data_i),
		.ready_i(st_free), .ack_o(issue_ack_o), .valid_o(issue_v), .data_o(issue_q)
	);

	// Writebacks are always accepted
	req_ack_rx #(.PAYLOAD_T(sched_pkg::wb_t)) wb_rx_inst (
		.clk_i(clk_i), .rst_i(rst_i), .req_i(wb_req_i), .data_i(wb_data_i),
		.ready_i(1'b1), .ack_o(wb_ack_o), .valid_o(wb_v), .data_o(wb_q)
	);

	// ==================================================
	// Station, register file and validation
	// ==================================================

	// The captured writeback both writes the file and feeds the bypass
	phys_regfile regfile_inst (
		.clk_i(clk_i), .rst_i(rst_i), .alloc_i(issue_v), .alloc_tag_i(issue_q.dst),
		.wr_i(wb_v), .wr_data_i(wb_q), .rd_tag_i(rd_tag), .rd_oper_o(rf_oper)
	);

	validate_operand validate_inst (
		.oper_i(st_oper), .rf_oper_i(rf_oper), .bypass_i(wb_q), .bypass_v_i(wb_v),
		.oper_o(val_oper)
	);

	operand_station station_inst (
		.clk_i(clk_i), .rst_i(rst_i), .issue_v_i(issue_v), .issue_i(issue_q),
		.free_o(st_free), .rd_tag_o(rd_tag), .oper_o(st_oper), .oper_i(val_oper),
		.take_i(take), .offer_v_o(offer_v), .offer_o(offer)
	);

	// Output link to the functional unit
	dispatch_tx disp_tx_inst (
		.clk_i(clk_i), .rst_i(rst_i), .offer_v_i(offer_v), .offer_i(offer),
		.take_o(take), .req_o(disp_req_o), .data_o(disp_data_o), .ack_i(disp_ack_i)
	);

endmodule

// File: tests/tb_clock_gen.sv
/*
  Testbench clock with a 40 ns period
  Reset is high for the first 5 rising edges and drops on a falling edge
*/
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk_o,
	output logic rst_o
);

	initial begin
		clk_o = 1'b0;
		forever #20 clk_o = ~clk_o;
	end

	// Released on a falling edge like every other DUT input
	initial begin
		rst_o = 1'b1;
		repeat (5) @(posedge clk_o);
		@(negedge clk_o);
		rst_o = 1'b0;
	end

endmodule

// File: tests/tb_opval_top.sv
/*
  Directed testbench for the operand-capture stage
  Plays the issue and writeback senders and the dispatch receiver
  A reference model predicts every dispatch by instruction id
  Ids are unique per run, so a run holds at most 256 issues
  Sources never equal the destination of the same instruction
*/
`timescale 1ns/1ps
`include "opval_settings.svh"

module tb_opval_top;

	localparam int TMO = 200;
	localparam int SEL_ISSUE = 0;
	localparam int SEL_WB = 1;
	localparam int SEL_DISP = 2;

	logic clk;
	logic rst;
	logic issue_req_i;
	sched_pkg::issue_t issue_data_i;
	logic issue_ack_o;
	logic wb_req_i;
	sched_pkg::wb_t wb_data_i;
	logic wb_ack_o;
	logic disp_req_o;
	sched_pkg::dispatch_t disp_data_o;
	logic disp_ack_i;
	// Set to stall the dispatch link
	logic disp_hold;

	// Reference model of register values, ready bits and waiting instructions
	cpu_types_pkg::value_t m_val [`OPV_NPREG];
	logic m_rdy [`OPV_NPREG];
	sched_pkg::dispatch_t m_exp [256];
	logic m_live [256];
	logic m_pend_a [256];
	logic m_pend_b [256];
	cpu_types_pkg::preg_t m_src_a [256];
	cpu_types_pkg::preg_t m_src_b [256];
	int disp_cnt [256];
	int live_count;
	int next_id;
	int n_checks;
	int n_errors;
	int n_fails;

	tb_clock_gen clock_inst (.clk_o(clk), .rst_o(rst));

	opval_top opval_top_inst (
		.clk_i(clk), .rst_i(rst),
		.issue_req_i(issue_req_i), .issue_data_i(issue_data_i), .issue_ack_o(issue_ack_o),
		.wb_req_i(wb_req_i), .wb_data_i(wb_data_i), .wb_ack_o(wb_ack_o),
		.disp_req_o(disp_req_o), .disp_data_o(disp_data_o), .disp_ack_i(disp_ack_i)
	);

	// ==================================================
	// Compare and report
	// ==================================================

	task automatic check_bit(input logic got, input logic exp, input string name);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("ERROR t=%0t %s got=%b exp=%b", $time, name, got, exp);
		end
	endtask

	task automatic check_dispatch(input sched_pkg::dispatch_t got,
		input sched_pkg::dispatch_t exp, input string name);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("ERROR t=%0t %s got=%h exp=%h", $time, name, got, exp);
		end
	endtask

	task automatic report_failure(input string msg);
		n_fails++;
		$display("FAILURE t=%0t %s", $time, msg);
	endtask

	// ==================================================
	// Reference model
	// ==================================================

	// A ready source is known now and an unready one waits for its writeback
	task automatic model_issue(input sched_pkg::issue_t pkt);
		int k;
		k = int'(pkt.id);
		m_live[k] = 1'b1;
		live_count++;
		m_src_a[k] = pkt.src_a;
		m_src_b[k] = pkt.src_b;
		m_pend_a[k] = !m_rdy[pkt.src_a];
		m_pend_b[k] = !m_rdy[pkt.src_b];
		m_exp[k] = '{id: pkt.id, dst: pkt.dst, val_a: m_val[pkt.src_a], val_b: m_val[pkt.src_b]};
		m_rdy[pkt.dst] = 1'b0;
	endtask

	task automatic model_wb(input sched_pkg::wb_t pkt);
		m_val[pkt.tag] = pkt.val;
		m_rdy[pkt.tag] = 1'b1;
		for (int k = 0; k < 256; k++) begin
			if (m_live[k] && m_pend_a[k] && m_src_a[k] == pkt.tag) begin
				m_exp[k].val_a = pkt.val;
				m_pend_a[k] = 1'b0;
			end
			if (m_live[k] && m_pend_b[k] && m_src_b[k] == pkt.tag) begin
				m_exp[k].val_b = pkt.val;
				m_pend_b[k] = 1'b0;
			end
		end
	endtask

	task automatic take_dispatch(input sched_pkg::dispatch_t pkt);
		int k;
		k = int'(pkt.id);
		disp_cnt[k]++;
		if (!m_live[k]) begin
			report_failure($sformatf("dispatch of id %0d which is not waiting", k));
		end else begin
			if (m_pend_a[k] || m_pend_b[k])
				report_failure($sformatf("id %0d dispatched before its sources were written", k));
			else
				check_dispatch(pkt, m_exp[k], "disp_data_o");
			m_live[k] = 1'b0;
			live_count--;
		end
	endtask

	// ==================================================
	// Link drivers
	// ==================================================

	function automatic logic link_bit(input int sel);
		case (sel)
			SEL_ISSUE: return issue_ack_o;
			SEL_WB: return wb_ack_o;
			default: return disp_req_o;
		endcase
	endfunction

	task automatic wait_level(input int sel, input logic level, input string what);
		int t;
		t = 0;
		while (link_bit(sel) != level && t < TMO) begin
			@(negedge clk);
			t++;
		end
		if (link_bit(sel) != level) report_failure({"timed out waiting for ", what});
	endtask

	task automatic wait_live(input int target);
		int t;
		t = 0;
		while (live_count != target && t < TMO) begin
			@(negedge clk);
			t++;
		end
		if (live_count != target)
			report_failure($sformatf("%0d instructions still waiting, %0d expected",
				live_count, target));
	endtask

	// Checks that a bit stays low over a fixed window
	task automatic expect_low(input int sel, input int cycles, input string name);
		repeat (cycles) begin
			@(negedge clk);
			check_bit(link_bit(sel), 1'b0, name);
		end
	endtask

	task automatic start_issue(input int dst, input int sa, input int sb);
		sched_pkg::issue_t pkt;
		@(negedge clk);
		pkt.id = sched_pkg::id_t'(next_id);
		pkt.dst = cpu_types_pkg::preg_t'(dst);
		pkt.src_a = cpu_types_pkg::preg_t'(sa);
		pkt.src_b = cpu_types_pkg::preg_t'(sb);
		next_id++;
		model_issue(pkt);
		issue_data_i = pkt;
		issue_req_i = 1'b1;
	endtask

	task automatic finish_issue();
		wait_level(SEL_ISSUE, 1'b1, "issue_ack_o high");
		issue_req_i = 1'b0;
		wait_level(SEL_ISSUE, 1'b0, "issue_ack_o low");
	endtask

	task automatic send_issue(input int dst, input int sa, input int sb);
		start_issue(dst, sa, sb);
		finish_issue();
	endtask

	task automatic send_wb(input int tag, input cpu_types_pkg::value_t val);
		sched_pkg::wb_t pkt;
		@(negedge clk);
		pkt.tag = cpu_types_pkg::preg_t'(tag);
		pkt.val = val;
		model_wb(pkt);
		wb_data_i = pkt;
		wb_req_i = 1'b1;
		wait_level(SEL_WB, 1'b1, "wb_ack_o high");
		wb_req_i = 1'b0;
		wait_level(SEL_WB, 1'b0, "wb_ack_o low");
	endtask

	// The functional unit side answers each request unless stalled
	initial begin
		disp_ack_i = 1'b0;
		forever begin
			@(negedge clk);
			if (!disp_ack_i && disp_req_o && !disp_hold) begin
				take_dispatch(disp_data_o);
				disp_ack_i = 1'b1;
			end else if (disp_ack_i && !disp_req_o) begin
				disp_ack_i = 1'b0;
			end
		end
	end

	// ==================================================
	// Directed tests
	// ==================================================

	task automatic reset_and_first_issue();
		check_bit(issue_ack_o, 1'b0, "issue_ack_o");
		check_bit(wb_ack_o, 1'b0, "wb_ack_o");
		check_bit(disp_req_o, 1'b0, "disp_req_o");
		// Tags 2 and 3 were never written so both values are zero
		send_issue(1, 2, 3);
		wait_live(0);
	endtask

	task automatic dependency_release();
		send_issue(4, 5, 6);
		send_issue(7, 4, 5);
		// The producer leaves and the consumer must wait for tag 4
		wait_live(1);
		expect_low(SEL_DISP, 10, "disp_req_o");
		send_wb(4, cpu_types_pkg::value_t'($urandom()));
		wait_live(0);
	endtask

	task automatic shared_tag_release();
		send_issue(10, 16, 17);
		send_issue(11, 10, 12);
		send_issue(13, 14, 10);
		send_issue(15, 10, 10);
		wait_live(3);
		expect_low(SEL_DISP, 10, "disp_req_o");
		// One writeback frees all three
		send_wb(10, cpu_types_pkg::value_t'($urandom()));
		wait_live(0);
	endtask

	task automatic issue_backpressure();
		disp_hold = 1'b1;
		// The first one sits in the sender and blocks the link
		send_issue(20, 21, 22);
		wait_level(SEL_DISP, 1'b1, "disp_req_o high");
		for (int k = 0; k < `OPV_NENTRY; k++) begin
			send_issue(23 + k, 21, 22);
		end
		// Station is full so this one must not be acknowledged
		start_issue(28, 21, 22);
		expect_low(SEL_ISSUE, 20, "issue_ack_o");
		disp_hold = 1'b0;
		finish_issue();
		wait_live(0);
	endtask

	task automatic random_mix(input int n_ops);
		int dst;
		int sa;
		int sb;
		int unready [$];
		for (int k = 0; k < n_ops; k++) begin
			unready.delete();
			for (int tg = 0; tg < `OPV_NPREG; tg++) begin
				if (!m_rdy[tg]) unready.push_back(tg);
			end
			// Issue only while the station is sure to have room
			if (live_count >= `OPV_NENTRY || $urandom_range(99) < 40) begin
				if (unready.size() > 0 && $urandom_range(99) < 80)
					sa = unready[$urandom_range(unready.size() - 1)];
				else
					sa = $urandom_range(`OPV_NPREG - 1);
				send_wb(sa, cpu_types_pkg::value_t'($urandom()));
			end else begin
				dst = $urandom_range(`OPV_NPREG - 1);
				// Offsets of 1 or more keep both sources off the destination
				sa = (dst + 1 + $urandom_range(`OPV_NPREG - 2)) % `OPV_NPREG;
				sb = (dst + 1 + $urandom_range(`OPV_NPREG - 2)) % `OPV_NPREG;
				send_issue(dst, sa, sb);
			end
		end
		for (int tg = 0; tg < `OPV_NPREG; tg++) begin
			if (!m_rdy[tg]) send_wb(tg, cpu_types_pkg::value_t'($urandom()));
		end
		wait_live(0);
	endtask

	initial begin
		int t;
		void'($urandom(51));
		issue_req_i = 1'b0;
		issue_data_i = '0;
		wb_req_i = 1'b0;
		wb_data_i = '0;
		disp_hold = 1'b0;
		// Every register starts at zero and ready as in the DUT after reset
		for (int k = 0; k < `OPV_NPREG; k++) begin
			m_val[k] = '0;
			m_rdy[k] = 1'b1;
		end
		for (int k = 0; k < 256; k++) begin
			m_live[k] = 1'b0;
			disp_cnt[k] = 0;
		end
		live_count = 0;
		next_id = 0;
		n_checks = 0;
		n_errors = 0;
		n_fails = 0;
		t = 0;
		do begin
			@(negedge clk);
			t++;
		end while (rst && t < TMO);
		if (rst) report_failure("reset was never released");
		reset_and_first_issue();
		dependency_release();
		shared_tag_release();
		issue_backpressure();
		random_mix(40);
		for (int k = 0; k < next_id; k++) begin
			if (disp_cnt[k] != 1)
				report_failure($sformatf("id %0d dispatched %0d times", k, disp_cnt[k]));
		end
		$display("checks=%0d errors=%0d failures=%0d issued=%0d",
			n_checks, n_errors, n_fails, next_id);
		if (n_errors == 0 && n_fails == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// File: opval_top.f
+incdir+hdl
hdl/cpu_types_pkg.sv
hdl/sched_pkg.sv
hdl/req_ack_rx.sv
hdl/phys_regfile.sv
hdl/validate_operand.sv
hdl/operand_station.sv
hdl/dispatch_tx.sv
hdl/opval_top.sv
tests/tb_clock_gen.sv
tests/tb_opval_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it, and judges the result from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module tb_opval_top \
	-f opval_top.f -o tb_sim \
	&& ./obj_dir/tb_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "^STATUS: PASS$" sim.log && echo "Run passed" || { echo "Run failed"; exit 1; }
